// ==== verilog.f ====
+incdir+design
+incdir+tb
design/spiLoopPkg.sv
design/spiInputSync.sv
design/spiShifter.sv
design/spiCommandCtrl.sv
design/spiMemory.sv
design/spiLoopTop.sv
tb/spiLoopTb.sv

// ==== tb/spiLoopTasks.svh ====
`ifndef SPI_LOOP_TASKS_SVH
`define SPI_LOOP_TASKS_SVH

////////////////////////////////////////////////////////////
// Random data and cycle waits
////////////////////////////////////////////////////////////
function automatic logic [31:0] lcgNext();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Full-period 32-bit LCG
  return lcgState;
endfunction

// Counted wait on the falling edge, so it always ends
task automatic waitCycles(input int count);
  repeat (count) @(negedge SysClk);
endtask

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////
task automatic checkByte(input string name, input spiLoopPkg::spiByteT expected,
                         input spiLoopPkg::spiByteT actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end
endtask

task automatic checkWord(input string name, input spiLoopPkg::regWordT expected,
                         input spiLoopPkg::regWordT actual);
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end
endtask

////////////////////////////////////////////////////////////
// SPI master, mode 0
////////////////////////////////////////////////////////////
// Shifts nBits MSB first, a short count leaves a partial byte
task automatic spiBits(input spiLoopPkg::spiByteT txData, input int nBits,
                       output spiLoopPkg::spiByteT rxData);
  rxData = '0;
  for (int i = 7; i > 7 - nBits; i--) begin
    spiMosi = txData[i];  // Changes while spiClk is low
    waitCycles(4);
    rxData[i] = spiMiso;  // Sampled at the rising edge
    spiClk    = 1'b1;
    waitCycles(4);
    spiClk    = 1'b0;
  end
endtask

task automatic sendByte(input spiLoopPkg::spiByteT txData,
                        output spiLoopPkg::spiByteT rxData);
  spiBits(txData, 8, rxData);
endtask

task automatic beginPacket();
  spiSs = 1'b0;
  waitCycles(4);
endtask

task automatic endPacket();
  spiSs = 1'b1;
  waitCycles(4);
endtask

// Register command byte with write flag and index
function automatic spiLoopPkg::spiByteT regCommand(input spiLoopPkg::regAddrT idx,
                                                   input logic write);
  spiLoopPkg::spiByteT cmd;
  cmd = '0;
  cmd[`SPI_CMD_REG_BIT]                = 1'b1;
  cmd[`SPI_CMD_REG_WE_BIT]             = write;
  cmd[`SPI_REG_ADDR_BITS-1:0]          = idx;
  return cmd;
endfunction

////////////////////////////////////////////////////////////
// In-packet helpers, each keeps the model in step
////////////////////////////////////////////////////////////
task automatic storeBytes(input spiLoopPkg::spiByteT cmd, input int count);
  spiLoopPkg::spiByteT data;
  spiLoopPkg::spiByteT unused;
  logic [31:0]         rnd;
  sendByte(cmd, unused);
  if (cmd == `SPI_CMD_STORE_START) writePtr = '0;  // Restart from 0
  for (int k = 0; k < count; k++) begin
    rnd  = lcgNext();
    data = rnd[23:16];
    sendByte(data, unused);
    bufModel[writePtr] = data;
    bufKnown[writePtr] = 1'b1;
    writePtr++;
  end
endtask

task automatic fetchBytes(input spiLoopPkg::spiByteT cmd, input int count);
  spiLoopPkg::spiByteT got;
  logic [31:0]         rnd;
  sendByte(cmd, got);
  if (cmd == `SPI_CMD_FETCH_START) readPtr = '0;
  for (int k = 0; k < count; k++) begin
    rnd = lcgNext();
    sendByte(rnd[15:8], got);  // MOSI is don't-care while fetching
    if (bufKnown[readPtr]) checkByte("spiMiso", bufModel[readPtr], got);
    readPtr++;
  end
endtask

task automatic regWriteBytes(input spiLoopPkg::regAddrT idx, input spiLoopPkg::regWordT word);
  spiLoopPkg::spiByteT unused;
  sendByte(regCommand(idx, 1'b1), unused);
  for (int b = `SPI_REG_BYTES - 1; b >= 0; b--) begin
    sendByte(word[b*8 +: 8], unused);  // MSB first
  end
  regModel[idx] = word;
endtask

task automatic regReadBytes(input spiLoopPkg::regAddrT idx);
  spiLoopPkg::spiByteT got;
  spiLoopPkg::regWordT word;
  logic [31:0]         rnd;
  sendByte(regCommand(idx, 1'b0), got);
  for (int b = `SPI_REG_BYTES - 1; b >= 0; b--) begin
    rnd = lcgNext();
    sendByte(rnd[7:0], got);
    word[b*8 +: 8] = got;
  end
  checkWord("spiMiso", regModel[idx], word);
endtask

`endif

// ==== tb/spiLoopTb.sv ====
`timescale 1ns/10ps
`include "spiLoop_cfg.svh"

module spiLoopTb;

  logic SysClk;
  logic reset;
  logic spiClk;
  logic spiSs;
  logic spiMosi;
  logic spiMiso;

  // Expected contents of buffer and registers
  logic [31:0]         lcgState;
  spiLoopPkg::spiByteT bufModel [2**`SPI_BUF_ADDR_BITS];
  bit                  bufKnown [2**`SPI_BUF_ADDR_BITS];  // Written at least once
  spiLoopPkg::regWordT regModel [2**`SPI_REG_ADDR_BITS];
  spiLoopPkg::bufAddrT writePtr;
  spiLoopPkg::bufAddrT readPtr;

  `include "spiLoopTasks.svh"

  spiLoopTop UUT (
    .SysClk  (SysClk),
    .reset   (reset),
    .spiClk  (spiClk),
    .spiSs   (spiSs),
    .spiMosi (spiMosi),
    .spiMiso (spiMiso)
  );

  always #50 SysClk = ~SysClk;  // 100 ns period

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic storeThenFetch();
    beginPacket();
    storeBytes(`SPI_CMD_STORE_START, 16);
    endPacket();
    beginPacket();
    fetchBytes(`SPI_CMD_FETCH_START, 16);
    endPacket();
  endtask

  task automatic continuation();
    beginPacket();
    storeBytes(`SPI_CMD_STORE_START, 5);  // Bytes A
    endPacket();
    beginPacket();
    storeBytes(`SPI_CMD_STORE_MORE, 6);   // Bytes B follow A
    endPacket();
    beginPacket();
    fetchBytes(`SPI_CMD_FETCH_START, 7);
    endPacket();
    beginPacket();
    fetchBytes(`SPI_CMD_FETCH_MORE, 6);   // Picks up at byte 7
    endPacket();
  endtask

  task automatic registerAccess();
    logic [31:0] word3;
    logic [31:0] word12;
    word3  = lcgNext();
    word12 = lcgNext();
    beginPacket();
    regWriteBytes(4'd3, word3);
    endPacket();
    beginPacket();
    regWriteBytes(4'd12, word12);
    endPacket();
    beginPacket();
    regReadBytes(4'd3);
    endPacket();
    beginPacket();
    regReadBytes(4'd12);
    endPacket();
  endtask

  // Register read then a fresh command in the same packet
  task automatic readThenCommand();
    beginPacket();
    regReadBytes(4'd12);
    fetchBytes(`SPI_CMD_FETCH_START, 1);
    endPacket();
  endtask

  task automatic abortAndIgnore();
    spiLoopPkg::spiByteT unused;
    logic [31:0]         rnd;
    beginPacket();
    sendByte(`SPI_CMD_STORE_START, unused);
    writePtr = '0;
    spiBits(8'hA5, 4, unused);  // SS rises mid-byte
    endPacket();
    beginPacket();
    sendByte(8'd5, unused);     // Unknown command
    sendByte(8'hC3, unused);    // Looks like a register write
    for (int k = 0; k < 5; k++) begin
      rnd = lcgNext();
      sendByte(rnd[31:24], unused);
    end
    endPacket();
    beginPacket();
    fetchBytes(`SPI_CMD_FETCH_START, 16);
    endPacket();
    beginPacket();
    regReadBytes(4'd3);
    endPacket();
    beginPacket();
    regReadBytes(4'd12);
    endPacket();
  endtask

  // Watchdog for the whole run
  initial begin
    repeat (60000) @(posedge SysClk);
    $display("Timeout: test sequence did not complete in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  initial begin
    SysClk   = 1'b0;
    reset    = 1'b1;
    spiClk   = 1'b0;
    spiSs    = 1'b1;  // No packet
    spiMosi  = 1'b0;
    lcgState = 32'hff645415;
    writePtr = '0;
    readPtr  = '0;
    repeat (10) @(negedge SysClk);
    reset = 1'b0;
    waitCycles(4);
    storeThenFetch();
    continuation();
    registerAccess();
    readThenCommand();
    abortAndIgnore();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== design/spiLoopTop.sv ====
`timescale 1ns/10ps
`include "spiLoop_cfg.svh"

module spiLoopTop (
  input  logic SysClk,
  input  logic reset,
  input  logic spiClk,
  input  logic spiSs,
  input  logic spiMosi,
  output logic spiMiso
);

  spiLoopPkg::spiEventT spiEvent;     // Pins in SysClk domain
  spiLoopPkg::rxByteT   rxByte;
  spiLoopPkg::spiByteT  txByte;
  spiLoopPkg::bufWriteT bufWrite;
  spiLoopPkg::bufAddrT  bufReadAddr;
  spiLoopPkg::spiByteT  bufReadData;
  spiLoopPkg::regWriteT regWrite;
  spiLoopPkg::regWordT  regReadData;

  ////////////////////////////////////////////////////////////
  // SPI front end
  ////////////////////////////////////////////////////////////
  spiInputSync inputSync (
    .SysClk   (SysClk),
    .reset    (reset),
    .spiClk   (spiClk),
    .spiSs    (spiSs),
    .spiMosi  (spiMosi),
    .spiEvent (spiEvent)
  );

  spiShifter shifter (
    .SysClk   (SysClk),
    .reset    (reset),
    .spiEvent (spiEvent),
    .txByte   (txByte),
    .rxByte   (rxByte),
    .spiMiso  (spiMiso)
  );

  spiCommandCtrl commandCtrl (
    .SysClk      (SysClk),
    .reset       (reset),
    .spiEvent    (spiEvent),
    .rxByte      (rxByte),
    .bufReadData (bufReadData),
    .regReadData (regReadData),
    .bufWrite    (bufWrite),
    .bufReadAddr (bufReadAddr),
    .regWrite    (regWrite),
    .txByte      (txByte)
  );

  ////////////////////////////////////////////////////////////
  // Byte buffer and register bank
  ////////////////////////////////////////////////////////////
  spiMemory #(
    .DataT    (spiLoopPkg::spiByteT),
    .AddrBits (`SPI_BUF_ADDR_BITS)
  ) bufferMem (
    .SysClk    (SysClk),
    .writeEn   (bufWrite.writeEn),
    .writeAddr (bufWrite.addr),
    .readAddr  (bufReadAddr),
    .writeData (bufWrite.data),
    .readData  (bufReadData)
  );

  spiMemory #(
    .DataT    (spiLoopPkg::regWordT),
    .AddrBits (`SPI_REG_ADDR_BITS)
  ) regBank (
    .SysClk    (SysClk),
    .writeEn   (regWrite.writeEn),
    .writeAddr (regWrite.addr),
    .readAddr  (regWrite.addr),  // Same index for read and write
    .writeData (regWrite.data),
    .readData  (regReadData)
  );

endmodule

// ==== design/spiMemory.sv ====
`timescale 1ns/10ps

module spiMemory #(
  parameter type DataT    = logic [7:0],  // Entry payload
  parameter int  AddrBits = 12
) (
  input  logic                SysClk,
  input  logic                writeEn,
  input  logic [AddrBits-1:0] writeAddr,
  input  logic [AddrBits-1:0] readAddr,
  input  DataT                writeData,
  output DataT                readData
);

  localparam int Depth = 2 ** AddrBits;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  DataT mem [Depth];

  always_ff @(posedge SysClk) begin
    if (writeEn) begin
      mem[writeAddr] <= writeData;  // Single write port
    end
  end

  // Async read, data ready before the next SPI edge
  assign readData = mem[readAddr];

  // A write must hit a known location
  assert property (@(posedge SysClk)
    writeEn |-> !$isunknown(writeAddr));

endmodule

// ==== design/spiCommandCtrl.sv ====
`timescale 1ns/10ps
`include "spiLoop_cfg.svh"

module spiCommandCtrl (
  input  logic                 SysClk,
  input  logic                 reset,
  input  spiLoopPkg::spiEventT spiEvent,
  input  spiLoopPkg::rxByteT   rxByte,
  input  spiLoopPkg::spiByteT  bufReadData,
  input  spiLoopPkg::regWordT  regReadData,
  output spiLoopPkg::bufWriteT bufWrite,
  output spiLoopPkg::bufAddrT  bufReadAddr,
  output spiLoopPkg::regWriteT regWrite,
  output spiLoopPkg::spiByteT  txByte
);

  spiLoopPkg::ctrlStateT stateReg;
  spiLoopPkg::ctrlStateT state;      // Forced to waitCmd on a new packet
  spiLoopPkg::bufAddrT   writeAddr;  // Store pointer
  spiLoopPkg::bufAddrT   readAddr;   // Fetch pointer
  spiLoopPkg::regAddrT   regIdx;
  spiLoopPkg::spiByteT   cmd;
  logic [1:0]            byteCnt;    // Byte of the register word
  logic [23:0]           wordUpper;  // Upper three bytes of a write
  logic                  lastByte;

  assign state    = spiEvent.packetStart ? spiLoopPkg::waitCmd : stateReg;
  assign cmd      = rxByte.data;
  assign lastByte = (byteCnt == 2'(`SPI_REG_BYTES - 1));

  ////////////////////////////////////////////////////////////
  // Command FSM and pointers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge SysClk) begin
    if (reset) begin
      stateReg  <= spiLoopPkg::waitCmd;
      writeAddr <= '0;
      readAddr  <= '0;
      regIdx    <= '0;
      byteCnt   <= '0;
    end else begin
      stateReg <= state;  // Hold, or take the packet restart
      if (rxByte.byteValid) begin
        case (state)
          spiLoopPkg::waitCmd: begin
            byteCnt <= '0;
            if (cmd[`SPI_CMD_REG_BIT]) begin
              // Register access with the index in the low bits
              regIdx   <= cmd[`SPI_REG_ADDR_BITS-1:0];
              stateReg <= cmd[`SPI_CMD_REG_WE_BIT] ? spiLoopPkg::regBuild
                                                   : spiLoopPkg::regSend;
            end else if (cmd == `SPI_CMD_STORE_START) begin
              writeAddr <= '0;
              stateReg  <= spiLoopPkg::storing;
            end else if (cmd == `SPI_CMD_STORE_MORE) begin
              stateReg <= spiLoopPkg::storing;  // Keep old pointer
            end else if (cmd == `SPI_CMD_FETCH_START) begin
              readAddr <= '0;
              stateReg <= spiLoopPkg::fetching;
            end else if (cmd == `SPI_CMD_FETCH_MORE) begin
              stateReg <= spiLoopPkg::fetching;
            end else begin
              stateReg <= spiLoopPkg::idle;  // Unknown command waits for SS high
            end
          end
          spiLoopPkg::storing: begin
            writeAddr <= writeAddr + 1'b1;
          end
          spiLoopPkg::fetching: begin
            readAddr <= readAddr + 1'b1;  // Next byte loads during the gap
          end
          spiLoopPkg::regBuild, spiLoopPkg::regSend: begin
            byteCnt <= byteCnt + 2'd1;
            if (lastByte) begin
              stateReg <= spiLoopPkg::waitCmd;  // Word done
            end
          end
          default: begin
            stateReg <= state;  // idle ignores everything
          end
        endcase
      end
    end
  end

  // Incoming register word arrives MSB first
  always_ff @(posedge SysClk) begin
    if (rxByte.byteValid && state == spiLoopPkg::regBuild) begin
      wordUpper <= {wordUpper[15:0], rxByte.data};
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory ports
  ////////////////////////////////////////////////////////////
  assign bufWrite.writeEn = rxByte.byteValid && (state == spiLoopPkg::storing);
  assign bufWrite.addr    = writeAddr;
  assign bufWrite.data    = rxByte.data;
  assign bufReadAddr      = readAddr;

  assign regWrite.writeEn = rxByte.byteValid && (state == spiLoopPkg::regBuild)
                            && lastByte;
  assign regWrite.addr    = regIdx;  // Read index too
  assign regWrite.data    = {wordUpper, rxByte.data};  // Last byte taken live

  // Byte for the next SPI transfer
  always_comb begin
    case (state)
      spiLoopPkg::fetching: txByte = bufReadData;
      // ~byteCnt counts 3..0, so byte 0 is bits 31:24
      spiLoopPkg::regSend:  txByte = regReadData[{~byteCnt, 3'b000} +: 8];
      default:              txByte = '0;
    endcase
  end

  // A packet restart never lands on a completed byte
  assert property (@(posedge SysClk) disable iff (reset)
    rxByte.byteValid |-> !spiEvent.packetStart);

endmodule

// ==== design/spiShifter.sv ====
`timescale 1ns/10ps

module spiShifter (
  input  logic                 SysClk,
  input  logic                 reset,
  input  spiLoopPkg::spiEventT spiEvent,
  input  spiLoopPkg::spiByteT  txByte,
  output spiLoopPkg::rxByteT   rxByte,
  output logic                 spiMiso
);

  ////////////////////////////////////////////////////////////
  // Bit counter shared by MOSI and MISO
  ////////////////////////////////////////////////////////////
  logic [2:0] bitIdxReg;  // Next bit position from the MSB down
  logic [2:0] bitIdx;     // Restarted by a new packet
  logic [6:0] rxUpper;    // Bits 7..1 of the byte in flight

  assign bitIdx = spiEvent.packetStart ? 3'd7 : bitIdxReg;

  always_ff @(posedge SysClk) begin
    if (reset) begin
      bitIdxReg <= 3'd7;
    end else if (spiEvent.bitStrobe) begin
      bitIdxReg <= bitIdx - 3'd1;  // Wraps 0 -> 7 at byte end
    end else begin
      bitIdxReg <= bitIdx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge SysClk) begin
    if (spiEvent.bitStrobe) begin
      rxUpper <= {rxUpper[5:0], spiEvent.mosiBit};  // Shift in MSB first
    end
  end

  // Last bit goes straight through without an extra cycle
  assign rxByte.byteValid = spiEvent.bitStrobe && (bitIdx == 3'd0);
  assign rxByte.data      = {rxUpper, spiEvent.mosiBit};

  // Transmit side
  assign spiMiso = txByte[bitIdx];  // Settles while spiClk is low

  // Completed byte holds only shifted-in bits
  assert property (@(posedge SysClk) disable iff (reset)
    rxByte.byteValid |-> !$isunknown(rxByte.data));

endmodule

// ==== design/spiInputSync.sv ====
`timescale 1ns/10ps

module spiInputSync (
  input  logic                 SysClk,
  input  logic                 reset,
  input  logic                 spiClk,
  input  logic                 spiSs,
  input  logic                 spiMosi,
  output spiLoopPkg::spiEventT spiEvent
);

  logic spiClkReg;   // Pins after one SysClk stage
  logic spiSsReg;
  logic spiMosiReg;
  logic spiClkPrev;  // Previous registered values
  logic spiSsPrev;
  logic clkRise;
  logic ssFall;

  always_ff @(posedge SysClk) begin
    if (reset) begin
      spiClkReg  <= 1'b0;
      spiSsReg   <= 1'b1;  // Bus idle with no packet
      spiClkPrev <= 1'b0;
      spiSsPrev  <= 1'b1;
    end else begin
      spiClkReg  <= spiClk;
      spiSsReg   <= spiSs;
      spiClkPrev <= spiClkReg;
      spiSsPrev  <= spiSsReg;
    end
  end

  always_ff @(posedge SysClk) begin
    spiMosiReg <= spiMosi;  // Stable while spiClk is high
  end

  assign clkRise = spiClkReg & ~spiClkPrev;  // Mode 0 sample edge
  assign ssFall  = spiSsPrev & ~spiSsReg;

  // Strobes leave on a register
  always_ff @(posedge SysClk) begin
    if (reset) begin
      spiEvent <= '0;
    end else begin
      spiEvent.bitStrobe   <= clkRise & ~spiSsReg;  // Only inside a packet
      spiEvent.packetStart <= ssFall;
      spiEvent.mosiBit     <= spiMosiReg;
    end
  end

  // Slave stays selected while a bit is handed on
  assert property (@(posedge SysClk) disable iff (reset)
    spiEvent.bitStrobe |-> !spiSsReg);

endmodule

// ==== design/spiLoopPkg.sv ====
package spiLoopPkg;

`include "spiLoop_cfg.svh"

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////
  typedef logic [`SPI_BYTE_BITS-1:0]     spiByteT;  // Data byte
  typedef logic [`SPI_WORD_BITS-1:0]     regWordT;  // Register word
  typedef logic [`SPI_BUF_ADDR_BITS-1:0] bufAddrT;  // Buffer address
  typedef logic [`SPI_REG_ADDR_BITS-1:0] regAddrT;  // Register index

  // Sampled SPI pins, already in SysClk domain
  typedef struct packed {
    logic bitStrobe;    // One cycle per rising spiClk inside a packet
    logic packetStart;  // One cycle per falling spiSs
    logic mosiBit;      // MOSI value for this strobe
  } spiEventT;

  typedef struct packed {
    logic    byteValid;  // Eighth bit of a byte
    spiByteT data;
  } rxByteT;

  typedef struct packed {
    logic    writeEn;
    bufAddrT addr;
    spiByteT data;
  } bufWriteT;

  typedef struct packed {
    logic    writeEn;
    regAddrT addr;  // Also the register read index
    regWordT data;
  } regWriteT;

  // Command FSM, idle swallows bytes of an unknown command
  typedef enum logic [2:0] {
    waitCmd, storing, fetching, regBuild, regSend, idle
  } ctrlStateT;

endpackage

// ==== design/spiLoop_cfg.svh ====
`ifndef SPI_LOOP_CFG_SVH
`define SPI_LOOP_CFG_SVH

////////////////////////////////////////////////////////////
// Widths and depths
////////////////////////////////////////////////////////////
`define SPI_BYTE_BITS      8   // One SPI transfer unit
`define SPI_WORD_BITS      32  // Register word
`define SPI_BUF_ADDR_BITS  12  // 4K byte buffer
`define SPI_REG_ADDR_BITS  4   // 16 registers
`define SPI_REG_BYTES      4   // Bytes per register word

////////////////////////////////////////////////////////////
// Command byte codes
////////////////////////////////////////////////////////////
`define SPI_CMD_STORE_START  8'd1  // Write buffer from address 0
`define SPI_CMD_STORE_MORE   8'd2  // Write buffer from current address
`define SPI_CMD_FETCH_START  8'd3  // Read buffer from address 0
`define SPI_CMD_FETCH_MORE   8'd4  // Read buffer from current address

// Register command fields
`define SPI_CMD_REG_BIT     7  // Set for any register access
`define SPI_CMD_REG_WE_BIT  6  // Set for a register write

`endif
